// ==== design/dram_sched_pkg.sv ====
/*
 * shared widths, timing defaults, APB register map and enums for the DRAM scheduler
 * address layout is row | bank group | bank | column, with the column in the low bits
 * FIFO_DEPTH must be a power of two because the queue pointers wrap freely
 * timing fields are TIMER_W bits wide, and a programmed value of 0 acts like 1
 */
package dram_sched_pkg;

	// request address geometry
	localparam int ADDR_W    = 16;
	localparam int COL_W     = 6;
	localparam int BANK_W    = 2;
	localparam int BG_W      = 2;
	localparam int ROW_W     = 6;
	localparam int COL_LSB   = 0;
	localparam int BANK_LSB  = COL_LSB + COL_W;   // bits 7..6
	localparam int BG_LSB    = BANK_LSB + BANK_W; // bits 9..8
	localparam int ROW_LSB   = BG_LSB + BG_W;     // bits 15..10
	localparam int BIDX_W    = BG_W + BANK_W;     // flat bank index {bg, bank}
	localparam int NUM_BANKS = 1 << BIDX_W;

	// queue and counter sizes
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int TIMER_W    = 8;
	localparam int REFI_W     = 16;

	// APB bus widths
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// timing register reset values, in clock cycles
	localparam logic [TIMER_W-1:0] T_RCD_DEF  = TIMER_W'(4);
	localparam logic [TIMER_W-1:0] T_RP_DEF   = TIMER_W'(4);
	localparam logic [TIMER_W-1:0] T_RAS_DEF  = TIMER_W'(10);
	localparam logic [TIMER_W-1:0] T_RFC_DEF  = TIMER_W'(12);
	localparam logic [REFI_W-1:0]  T_REFI_DEF = REFI_W'(2000);

	// register map, byte offsets
	localparam logic [APB_AW-1:0] REG_CTRL  = APB_AW'('h00); // bit 0 = scheduler enable
	localparam logic [APB_AW-1:0] REG_TRCD  = APB_AW'('h04);
	localparam logic [APB_AW-1:0] REG_TRP   = APB_AW'('h08);
	localparam logic [APB_AW-1:0] REG_TRAS  = APB_AW'('h0C);
	localparam logic [APB_AW-1:0] REG_TRFC  = APB_AW'('h10);
	localparam logic [APB_AW-1:0] REG_TREFI = APB_AW'('h14);

	typedef enum logic [2:0] {NOP, ACT, RD, WR, PRE, PREA, REF} dram_cmd_e;

	// which command the running sequence needs next
	typedef enum logic [2:0] {
		IDLE,        // no request in sequence
		PRECHARGING, // row miss, PRE pending
		ACTIVATING,  // bank closed, ACT pending
		ACCESS,      // row open, RD/WR pending
		REF_PREA,    // refresh, PREA pending
		REF_WAIT     // refresh, REF pending
	} bank_state_e;

endpackage

// ==== design/req_fifo.sv ====
/*
 * in-order request queue, valid/ready on the push side
 * req_ready is registered, low in reset and whenever the queue is full
 * head fields are only meaningful while head_valid is high
 * head_pop must not be raised on an empty queue
 */
`timescale 1ns/1ps

module req_fifo (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              req_valid,
	input  logic                              req_write,
	input  logic [dram_sched_pkg::ADDR_W-1:0] req_addr,
	input  logic                              head_pop,
	output logic                              req_ready,
	output logic                              head_valid,
	output logic                              head_write,
	output logic [dram_sched_pkg::ADDR_W-1:0] head_addr
);

	logic                              mem_write [dram_sched_pkg::FIFO_DEPTH];
	logic [dram_sched_pkg::ADDR_W-1:0] mem_addr  [dram_sched_pkg::FIFO_DEPTH];
	logic [dram_sched_pkg::FIFO_PTR_W-1:0] wr_ptr, rd_ptr;
	logic [dram_sched_pkg::FIFO_PTR_W:0]   count, count_nxt; // one extra bit for full
	logic push;

	assign push = req_valid && req_ready;

	always_comb begin
		count_nxt = count;
		if (push && !head_pop) count_nxt = count + 1'b1;
		else if (!push && head_pop) count_nxt = count - 1'b1; // push+pop leaves count as is
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			req_ready <= 1'b0;
		end else begin
			count     <= count_nxt;
			req_ready <= !count_nxt[dram_sched_pkg::FIFO_PTR_W]; // msb set only at FIFO_DEPTH
			if (push) wr_ptr <= wr_ptr + 1'b1;     // wraps at depth
			if (head_pop) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// storage, no reset needed
	always_ff @(posedge clk) begin
		if (push) begin
			mem_write[wr_ptr] <= req_write;
			mem_addr[wr_ptr]  <= req_addr;
		end
	end

	assign head_valid = (count != '0);
	assign head_write = mem_write[rd_ptr];
	assign head_addr  = mem_addr[rd_ptr];

	// scheduler only pops a request it has actually seen
	a_pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n) head_pop |-> head_valid);

endmodule

// ==== design/timing_regs.sv ====
/*
 * APB slave holding the DRAM timing values and the scheduler enable
 * pready is tied high, so every transfer ends in its access phase
 * writes land at the end of the access phase, unmapped offsets give pslverr
 * new timing values apply to commands issued after the write
 */
`timescale 1ns/1ps

module timing_regs (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic [dram_sched_pkg::APB_AW-1:0]  paddr,
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pwrite,
	input  logic [dram_sched_pkg::APB_DW-1:0]  pwdata,
	output logic [dram_sched_pkg::APB_DW-1:0]  prdata,
	output logic                               pready,
	output logic                               pslverr,
	output logic                               sched_en,
	output logic [dram_sched_pkg::TIMER_W-1:0] t_rcd,
	output logic [dram_sched_pkg::TIMER_W-1:0] t_rp,
	output logic [dram_sched_pkg::TIMER_W-1:0] t_ras,
	output logic [dram_sched_pkg::TIMER_W-1:0] t_rfc,
	output logic [dram_sched_pkg::REFI_W-1:0]  t_refi
);

	logic mapped; // offset hits a register
	logic wr_en;

	// address decode and read mux
	always_comb begin
		mapped = 1'b1;
		prdata = '0;
		case (paddr)
			dram_sched_pkg::REG_CTRL:  prdata[0] = sched_en;
			dram_sched_pkg::REG_TRCD:  prdata[dram_sched_pkg::TIMER_W-1:0] = t_rcd;
			dram_sched_pkg::REG_TRP:   prdata[dram_sched_pkg::TIMER_W-1:0] = t_rp;
			dram_sched_pkg::REG_TRAS:  prdata[dram_sched_pkg::TIMER_W-1:0] = t_ras;
			dram_sched_pkg::REG_TRFC:  prdata[dram_sched_pkg::TIMER_W-1:0] = t_rfc;
			dram_sched_pkg::REG_TREFI: prdata[dram_sched_pkg::REFI_W-1:0] = t_refi;
			default:                   mapped = 1'b0;
		endcase
	end

	assign pready  = 1'b1; // zero wait states
	assign pslverr = psel && penable && !mapped;
	assign wr_en   = psel && penable && pwrite && mapped;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sched_en <= 1'b1; // scheduler runs out of reset
			t_rcd    <= dram_sched_pkg::T_RCD_DEF;
			t_rp     <= dram_sched_pkg::T_RP_DEF;
			t_ras    <= dram_sched_pkg::T_RAS_DEF;
			t_rfc    <= dram_sched_pkg::T_RFC_DEF;
			t_refi   <= dram_sched_pkg::T_REFI_DEF;
		end else if (wr_en) begin
			case (paddr)
				dram_sched_pkg::REG_CTRL:  sched_en <= pwdata[0];
				dram_sched_pkg::REG_TRCD:  t_rcd <= pwdata[dram_sched_pkg::TIMER_W-1:0];
				dram_sched_pkg::REG_TRP:   t_rp <= pwdata[dram_sched_pkg::TIMER_W-1:0];
				dram_sched_pkg::REG_TRAS:  t_ras <= pwdata[dram_sched_pkg::TIMER_W-1:0];
				dram_sched_pkg::REG_TRFC:  t_rfc <= pwdata[dram_sched_pkg::TIMER_W-1:0];
				dram_sched_pkg::REG_TREFI: t_refi <= pwdata[dram_sched_pkg::REFI_W-1:0];
				default: ; // not reachable, wr_en needs a mapped offset
			endcase
		end
	end

	// access phase only ever follows a select from the master
	a_penable_needs_psel: assert property (
		@(posedge clk) disable iff (!rst_n) penable |-> psel
	);

endmodule

// ==== design/refresh_timer.sv ====
/*
 * refresh interval counter
 * ref_req rises when the count hits zero and holds until ref_done
 * lowering t_refi clamps a running count at once, raising it applies at the next reload
 * t_refi of 0 keeps ref_req asserted
 */
`timescale 1ns/1ps

module refresh_timer (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [dram_sched_pkg::REFI_W-1:0] t_refi,
	input  logic                              ref_done,
	output logic                              ref_req
);

	logic [dram_sched_pkg::REFI_W-1:0] refi_cnt; // cycles left to next refresh

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refi_cnt <= dram_sched_pkg::T_REFI_DEF;
			ref_req  <= 1'b0;
		end else if (ref_done) begin
			refi_cnt <= t_refi; // interval restarts when REF goes out
			ref_req  <= 1'b0;
		end else if (refi_cnt == '0) begin
			ref_req <= 1'b1; // hold until scheduler serves it
		end else if (refi_cnt > t_refi) begin
			refi_cnt <= t_refi; // shorter interval programmed mid-count
		end else begin
			refi_cnt <= refi_cnt - 1'b1;
		end
	end

endmodule

// ==== design/cmd_sched.sv ====
/*
 * DRAM command scheduler, one request in sequence at a time, strictly in order
 * per-bank tRCD, tRAS and tRP countdowns plus a global tRFC blackout
 * commands are combinational from state and queue head, one per cycle at most
 * pending refresh wins only between requests, PREA then REF
 * sched_en low freezes issue, the queue keeps filling
 */
`timescale 1ns/1ps

module cmd_sched (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               sched_en,
	input  logic [dram_sched_pkg::TIMER_W-1:0] t_rcd,
	input  logic [dram_sched_pkg::TIMER_W-1:0] t_rp,
	input  logic [dram_sched_pkg::TIMER_W-1:0] t_ras,
	input  logic [dram_sched_pkg::TIMER_W-1:0] t_rfc,
	input  logic                               head_valid,
	input  logic                               head_write,
	input  logic [dram_sched_pkg::ADDR_W-1:0]  head_addr,
	input  logic                               ref_req,
	output logic                               head_pop,
	output logic                               ref_done,
	output logic                               cmd_valid,
	output dram_sched_pkg::dram_cmd_e          cmd_op,
	output logic [dram_sched_pkg::BG_W-1:0]    cmd_bg,
	output logic [dram_sched_pkg::BANK_W-1:0]  cmd_bank,
	output logic [dram_sched_pkg::ROW_W-1:0]   cmd_row,
	output logic [dram_sched_pkg::COL_W-1:0]   cmd_col
);

	logic [dram_sched_pkg::NUM_BANKS-1:0] bank_open;
	logic [dram_sched_pkg::ROW_W-1:0]   open_row [dram_sched_pkg::NUM_BANKS];
	logic [dram_sched_pkg::TIMER_W-1:0] rcd_cnt  [dram_sched_pkg::NUM_BANKS]; // act -> rd/wr
	logic [dram_sched_pkg::TIMER_W-1:0] ras_cnt  [dram_sched_pkg::NUM_BANKS]; // act -> pre
	logic [dram_sched_pkg::TIMER_W-1:0] rp_cnt   [dram_sched_pkg::NUM_BANKS]; // pre -> act
	logic [dram_sched_pkg::TIMER_W-1:0] rfc_cnt;                              // ref -> any
	dram_sched_pkg::bank_state_e state, state_nxt, seq;
	logic [dram_sched_pkg::BIDX_W-1:0] hd_idx;
	logic row_hit, ras_all_clear, rp_all_clear, can_issue, all_bank_cmd;

	// a count of t-1 reaches zero exactly t cycles after the command edge
	function automatic logic [dram_sched_pkg::TIMER_W-1:0] load_val(
		input logic [dram_sched_pkg::TIMER_W-1:0] t
	);
		return (t == '0) ? '0 : t - 1'b1;
	endfunction

	assign hd_idx  = head_addr[dram_sched_pkg::BANK_LSB +: dram_sched_pkg::BIDX_W]; // {bg, bank}
	assign row_hit = bank_open[hd_idx]
		&& (open_row[hd_idx] == head_addr[dram_sched_pkg::ROW_LSB +: dram_sched_pkg::ROW_W]);

	always_comb begin
		ras_all_clear = 1'b1;
		rp_all_clear  = 1'b1;
		for (int i = 0; i < dram_sched_pkg::NUM_BANKS; i++) begin
			if (bank_open[i] && ras_cnt[i] != '0) ras_all_clear = 1'b0; // closed banks don't care
			if (rp_cnt[i] != '0) rp_all_clear = 1'b0;
		end
	end

	// from IDLE pick the sequence, otherwise keep the one in flight
	always_comb begin
		seq = state;
		if (state == dram_sched_pkg::IDLE) begin
			if (ref_req) seq = dram_sched_pkg::REF_PREA;
			else if (head_valid && row_hit) seq = dram_sched_pkg::ACCESS;
			else if (head_valid && bank_open[hd_idx]) seq = dram_sched_pkg::PRECHARGING;
			else if (head_valid) seq = dram_sched_pkg::ACTIVATING;
		end
	end

	assign can_issue = sched_en && (rfc_cnt == '0);

	always_comb begin
		cmd_op    = dram_sched_pkg::NOP;
		state_nxt = state;
		if (can_issue) begin
			case (seq)
				dram_sched_pkg::PRECHARGING: if (ras_cnt[hd_idx] == '0) cmd_op = dram_sched_pkg::PRE;
				dram_sched_pkg::ACTIVATING:  if (rp_cnt[hd_idx] == '0) cmd_op = dram_sched_pkg::ACT;
				dram_sched_pkg::ACCESS: begin
					if (rcd_cnt[hd_idx] == '0)
						cmd_op = head_write ? dram_sched_pkg::WR : dram_sched_pkg::RD;
				end
				dram_sched_pkg::REF_PREA: if (ras_all_clear) cmd_op = dram_sched_pkg::PREA;
				dram_sched_pkg::REF_WAIT: if (rp_all_clear) cmd_op = dram_sched_pkg::REF;
				default: ;
			endcase
			state_nxt = seq; // waiting on a timer keeps the chosen sequence
			case (cmd_op)
				dram_sched_pkg::PRE:  state_nxt = dram_sched_pkg::ACTIVATING;
				dram_sched_pkg::ACT:  state_nxt = dram_sched_pkg::ACCESS;
				dram_sched_pkg::PREA: state_nxt = dram_sched_pkg::REF_WAIT;
				dram_sched_pkg::RD, dram_sched_pkg::WR, dram_sched_pkg::REF:
					state_nxt = dram_sched_pkg::IDLE;
				default: ;
			endcase
		end
	end

	assign cmd_valid    = (cmd_op != dram_sched_pkg::NOP);
	assign head_pop     = (cmd_op == dram_sched_pkg::RD) || (cmd_op == dram_sched_pkg::WR);
	assign ref_done     = (cmd_op == dram_sched_pkg::REF);
	assign all_bank_cmd = (cmd_op == dram_sched_pkg::PREA) || ref_done; // no address on these
	assign cmd_bg   = all_bank_cmd ? '0
		: head_addr[dram_sched_pkg::BG_LSB +: dram_sched_pkg::BG_W];
	assign cmd_bank = all_bank_cmd ? '0
		: head_addr[dram_sched_pkg::BANK_LSB +: dram_sched_pkg::BANK_W];
	assign cmd_row  = all_bank_cmd ? '0
		: head_addr[dram_sched_pkg::ROW_LSB +: dram_sched_pkg::ROW_W];
	assign cmd_col  = all_bank_cmd ? '0
		: head_addr[dram_sched_pkg::COL_LSB +: dram_sched_pkg::COL_W];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= dram_sched_pkg::IDLE;
			bank_open <= '0;
			rfc_cnt   <= '0;
			for (int i = 0; i < dram_sched_pkg::NUM_BANKS; i++) begin
				rcd_cnt[i] <= '0;
				ras_cnt[i] <= '0;
				rp_cnt[i]  <= '0;
			end
		end else begin
			state <= state_nxt;
			if (rfc_cnt != '0) rfc_cnt <= rfc_cnt - 1'b1;
			for (int i = 0; i < dram_sched_pkg::NUM_BANKS; i++) begin // saturating countdowns
				if (rcd_cnt[i] != '0) rcd_cnt[i] <= rcd_cnt[i] - 1'b1;
				if (ras_cnt[i] != '0) ras_cnt[i] <= ras_cnt[i] - 1'b1;
				if (rp_cnt[i] != '0) rp_cnt[i] <= rp_cnt[i] - 1'b1;
			end
			case (cmd_op) // later loads override the decrement above
				dram_sched_pkg::ACT: begin
					bank_open[hd_idx] <= 1'b1;
					rcd_cnt[hd_idx]   <= load_val(t_rcd);
					ras_cnt[hd_idx]   <= load_val(t_ras);
				end
				dram_sched_pkg::PRE: begin
					bank_open[hd_idx] <= 1'b0;
					rp_cnt[hd_idx]    <= load_val(t_rp);
				end
				dram_sched_pkg::PREA: begin
					bank_open <= '0;
					for (int i = 0; i < dram_sched_pkg::NUM_BANKS; i++) rp_cnt[i] <= load_val(t_rp);
				end
				dram_sched_pkg::REF: rfc_cnt <= load_val(t_rfc);
				default: ;
			endcase
		end
	end

	// open row only matters while bank_open is set
	always_ff @(posedge clk) begin
		if (cmd_op == dram_sched_pkg::ACT) open_row[hd_idx] <= cmd_row;
	end

	// column access lands on the row an earlier ACT opened
	a_col_on_open_row: assert property (@(posedge clk) disable iff (!rst_n)
		head_pop |-> bank_open[{cmd_bg, cmd_bank}] && open_row[{cmd_bg, cmd_bank}] == cmd_row);
	// nothing issues in the cycle after a REF while t_rfc exceeds one
	a_rfc_blackout: assert property (@(posedge clk) disable iff (!rst_n)
		ref_done && t_rfc > 1 |=> !cmd_valid);

endmodule

// ==== design/dram_ctrl_top.sv ====
/*
 * DRAM controller top: request queue, APB timing registers, refresh timer, scheduler
 * command port has no back-pressure, the DRAM takes every command
 * APB slave has no wait states
 */
`timescale 1ns/1ps

module dram_ctrl_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              req_valid,
	input  logic                              req_write,
	input  logic [dram_sched_pkg::ADDR_W-1:0] req_addr,
	output logic                              req_ready,
	input  logic [dram_sched_pkg::APB_AW-1:0] paddr,
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [dram_sched_pkg::APB_DW-1:0] pwdata,
	output logic [dram_sched_pkg::APB_DW-1:0] prdata,
	output logic                              pready,
	output logic                              pslverr,
	output logic                              cmd_valid,
	output dram_sched_pkg::dram_cmd_e         cmd_op,
	output logic [dram_sched_pkg::BG_W-1:0]   cmd_bg,
	output logic [dram_sched_pkg::BANK_W-1:0] cmd_bank,
	output logic [dram_sched_pkg::ROW_W-1:0]  cmd_row,
	output logic [dram_sched_pkg::COL_W-1:0]  cmd_col
);

	logic head_valid, head_write, head_pop; // queue head to scheduler
	logic [dram_sched_pkg::ADDR_W-1:0] head_addr;
	logic sched_en, ref_req, ref_done;
	logic [dram_sched_pkg::TIMER_W-1:0] t_rcd, t_rp, t_ras, t_rfc;
	logic [dram_sched_pkg::REFI_W-1:0] t_refi;

	req_fifo u_fifo (.clk, .rst_n, .req_valid, .req_write, .req_addr, .head_pop,
		.req_ready, .head_valid, .head_write, .head_addr);

	timing_regs u_regs (.clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
		.prdata, .pready, .pslverr, .sched_en, .t_rcd, .t_rp, .t_ras, .t_rfc, .t_refi);

	refresh_timer u_refresh (.clk, .rst_n, .t_refi, .ref_done, .ref_req);

	cmd_sched u_sched (.clk, .rst_n, .sched_en, .t_rcd, .t_rp, .t_ras, .t_rfc,
		.head_valid, .head_write, .head_addr, .ref_req, .head_pop, .ref_done,
		.cmd_valid, .cmd_op, .cmd_bg, .cmd_bank, .cmd_row, .cmd_col);

endmodule

// ==== verif/tb_dram_ctrl.sv ====
/*
 * directed testbench for the DRAM controller top
 * commands are sampled on the rising edge into a log with their cycle number
 * timing checks are minimum spacings only
 * the programmed timing values are mirrored in localparams
 * the first failed check ends the run
 */
`timescale 1ns/1ps

module tb_dram_ctrl;

	localparam int CYCLE_NS = 100;
	localparam int T_RCD = 5, T_RP = 6, T_RAS = 12, T_RFC = 10; // values written by reg_map
	localparam int BUDGET_CYCLES = 10 + 80 + 40 + 40 + 50 + 130 + 60; // reset + six tests

	logic clk, rst_n, req_valid, req_write, req_ready, psel, penable, pwrite, pready, pslverr;
	logic [dram_sched_pkg::ADDR_W-1:0] req_addr;
	logic [dram_sched_pkg::APB_AW-1:0] paddr;
	logic [dram_sched_pkg::APB_DW-1:0] pwdata, prdata;
	logic cmd_valid;
	dram_sched_pkg::dram_cmd_e cmd_op;
	logic [dram_sched_pkg::BG_W-1:0] cmd_bg;
	logic [dram_sched_pkg::BANK_W-1:0] cmd_bank;
	logic [dram_sched_pkg::ROW_W-1:0] cmd_row;
	logic [dram_sched_pkg::COL_W-1:0] cmd_col;

	dram_sched_pkg::dram_cmd_e log_op[$]; // one entry per issued command
	logic [15:0] log_addr[$];             // {row, bg, bank, col} as on the request side
	int log_cyc[$];
	int cyc = 0;

	dram_ctrl_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CYCLE_NS / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cyc++;
			if (cmd_valid) begin
				log_op.push_back(cmd_op);
				log_addr.push_back({cmd_row, cmd_bg, cmd_bank, cmd_col});
				log_cyc.push_back(cyc);
			end
		end
	end

	task automatic abort();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("ERROR at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
			abort();
		end
	endtask

	task automatic min_gap(input string what, input int first, input int second, input int min);
		if (log_cyc[second] - log_cyc[first] < min) begin
			$display("%s came after %0d cycles, needs at least %0d (time %0t)", what,
				log_cyc[second] - log_cyc[first], min, $time);
			abort();
		end
	endtask

	// waits on the falling edge so the monitor has already logged this cycle
	task automatic wait_cmds(input int n);
		for (int i = 0; i < 200 && log_op.size() < n; i++) @(negedge clk);
		if (log_op.size() < n) begin
			$display("only %0d of %0d expected commands seen after 200 cycles", log_op.size(), n);
			abort();
		end
	endtask

	task automatic expect_cmd(input int idx, input dram_sched_pkg::dram_cmd_e op,
		input logic [15:0] addr);
		check("cmd_op", 32'(op), 32'(log_op[idx]));
		if (op == dram_sched_pkg::RD || op == dram_sched_pkg::WR)
			check("cmd_row/bg/bank/col", 32'(addr), 32'(log_addr[idx]));
		else if (op == dram_sched_pkg::ACT || op == dram_sched_pkg::PRE)
			check("cmd_row/bg/bank", 32'(addr[15:6]), 32'(log_addr[idx][15:6])); // no column
	endtask

	// builds a row | bg | bank | col address with a random column
	function automatic logic [15:0] mk_addr(input logic [5:0] row, input logic [1:0] bg,
		input logic [1:0] bank);
		return {row, bg, bank, 6'($urandom_range(63))};
	endfunction

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		@(posedge clk);
		paddr <= addr;
		pwdata <= data;
		pwrite <= 1'b1;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk); // access phase ends at this edge
		err = pslverr;
		check("pready", 1, 32'(pready));
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		paddr <= addr;
		pwrite <= 1'b0;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		data = prdata;
		err = pslverr;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic send_req(input logic write, input logic [15:0] addr);
		@(posedge clk);
		req_valid <= 1'b1;
		req_write <= write;
		req_addr <= addr;
		do @(posedge clk); while (!req_ready); // held until accepted
		req_valid <= 1'b0;
	endtask

	task automatic reg_map();
		logic [7:0] offs[6] = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h14};
		logic [31:0] defs[6] = '{32'd1, 32'd4, 32'd4, 32'd10, 32'd12, 32'd2000};
		logic [31:0] news[6] = '{32'd1, 32'd5, 32'd6, 32'd12, 32'd10, 32'd1500};
		logic [31:0] rd;
		logic err;
		for (int i = 0; i < 6; i++) begin
			apb_read(offs[i], rd, err);
			check("prdata reset value", defs[i], rd);
			check("pslverr", 0, 32'(err));
		end
		for (int i = 0; i < 6; i++) apb_write(offs[i], news[i], err);
		apb_write(8'h18, 32'hFE, err); // unmapped
		check("pslverr unmapped write", 1, 32'(err));
		apb_read(8'h1C, rd, err);
		check("pslverr unmapped read", 1, 32'(err));
		for (int i = 0; i < 6; i++) begin
			apb_read(offs[i], rd, err);
			check("prdata after write", news[i], rd);
		end
	endtask

	task automatic closed_bank();
		int base = log_op.size();
		logic [15:0] a = mk_addr(6'd3, 2'd1, 2'd2);
		send_req(1'b0, a);
		wait_cmds(base + 2);
		expect_cmd(base, dram_sched_pkg::ACT, a);
		expect_cmd(base + 1, dram_sched_pkg::RD, a);
		min_gap("RD after ACT", base, base + 1, T_RCD);
	endtask

	task automatic row_hit();
		int base = log_op.size();
		logic [15:0] a = mk_addr(6'd3, 2'd1, 2'd2); // same row as the closed-bank test
		send_req(1'b1, a);
		wait_cmds(base + 1);
		expect_cmd(base, dram_sched_pkg::WR, a);
		repeat (20) @(negedge clk);
		check("command count after row hit", base + 1, log_op.size()); // no PRE or ACT
	endtask

	task automatic row_miss();
		int base = log_op.size();
		logic [15:0] a = mk_addr(6'd4, 2'd0, 2'd1); // opens a fresh bank
		logic [15:0] b = mk_addr(6'd9, 2'd0, 2'd1); // other row queued right behind
		send_req(1'b0, a);
		send_req(1'b0, b);
		wait_cmds(base + 5);
		expect_cmd(base, dram_sched_pkg::ACT, a);
		expect_cmd(base + 1, dram_sched_pkg::RD, a);
		expect_cmd(base + 2, dram_sched_pkg::PRE, b);
		expect_cmd(base + 3, dram_sched_pkg::ACT, b);
		expect_cmd(base + 4, dram_sched_pkg::RD, b);
		min_gap("PRE after ACT", base, base + 2, T_RAS);
		min_gap("ACT after PRE", base + 2, base + 3, T_RP);
		min_gap("RD after ACT", base + 3, base + 4, T_RCD);
	endtask

	task automatic refresh_cycle();
		int base = log_op.size();
		logic [15:0] a = mk_addr(6'd20, 2'd2, 2'd0);
		logic [15:0] b = mk_addr(6'd20, 2'd2, 2'd0);
		logic err;
		apb_write(8'h00, 32'd0, err); // hold the scheduler while refresh comes due
		apb_write(8'h14, 32'd30, err);
		send_req(1'b0, a);
		send_req(1'b1, b);
		repeat (50) @(posedge clk);
		check("command count while disabled", base, log_op.size());
		apb_write(8'h14, 32'd2000, err); // next interval after REF is long again
		apb_write(8'h00, 32'd1, err);
		wait_cmds(base + 5);
		expect_cmd(base, dram_sched_pkg::PREA, a);
		expect_cmd(base + 1, dram_sched_pkg::REF, a);
		expect_cmd(base + 2, dram_sched_pkg::ACT, a);
		expect_cmd(base + 3, dram_sched_pkg::RD, a);
		expect_cmd(base + 4, dram_sched_pkg::WR, b);
		min_gap("REF after PREA", base, base + 1, T_RP);
		min_gap("command after REF", base + 1, base + 2, T_RFC);
	endtask

	task automatic backpressure();
		int base = log_op.size();
		dram_sched_pkg::dram_cmd_e ops[7] = '{dram_sched_pkg::ACT, dram_sched_pkg::RD,
			dram_sched_pkg::WR, dram_sched_pkg::PRE, dram_sched_pkg::ACT, dram_sched_pkg::RD,
			dram_sched_pkg::WR};
		int which[7] = '{0, 0, 1, 2, 2, 2, 3}; // request behind each command
		logic [15:0] addrs[4];
		logic err;
		apb_write(8'h00, 32'd0, err);
		for (int i = 0; i < 4; i++) begin
			addrs[i] = mk_addr((i < 2) ? 6'd1 : 6'd2, 2'd3, 2'd3);
			send_req(i[0], addrs[i]); // read, write, read, write
		end
		@(negedge clk);
		check("req_ready with full queue", 0, 32'(req_ready));
		apb_write(8'h00, 32'd1, err);
		wait_cmds(base + 7);
		for (int i = 0; i < 7; i++) expect_cmd(base + i, ops[i], addrs[which[i]]);
		@(negedge clk);
		check("req_ready after drain", 1, 32'(req_ready));
	endtask

	initial begin
		#(CYCLE_NS * 2 * BUDGET_CYCLES);
		$display("watchdog expired, tests did not finish within %0d cycles", 2 * BUDGET_CYCLES);
		abort();
	end

	initial begin
		void'($urandom(1764));
		rst_n <= 1'b0;
		req_valid <= 1'b0;
		req_write <= 1'b0;
		req_addr <= '0;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		reg_map();
		closed_bank();
		row_hit();
		row_miss();
		refresh_cycle();
		backpressure();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== flist.f ====
design/dram_sched_pkg.sv
design/req_fifo.sv
design/timing_regs.sv
design/refresh_timer.sv
design/cmd_sched.sv
design/dram_ctrl_top.sv
verif/tb_dram_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
verilator --binary --timing --assert -f flist.f --top-module tb_dram_ctrl -o tb_sim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -qx "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
